/* source/i3c_bus_pkg.sv */
package i3c_bus_pkg;

  // Bits in one byte on the bus
  localparam int ByteWidth = 8;

  // Bit counter covers the eight data bits and the ACK bit
  localparam int BitIdxWidth = 4;

  // Private transfer target address
  localparam int AddrWidth = 7;

  // Address byte layout, MSB first on the wire
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    // High for a read, low for a write
    logic                 rw;
  } bus_addr_t;

  // Captured byte
  // First byte after a Start is read through the address view,
  // every later byte through the data view
  typedef union packed {
    bus_addr_t            a;
    logic [ByteWidth-1:0] data;
  } bus_byte_u;

endpackage

/* source/i3c_target_pkg.sv */
package i3c_target_pkg;

  import i3c_bus_pkg::*;

  // Transfer states of the target
  typedef enum logic [4:0] {
    // Bus free, waiting for Start
    Idle,
    // Start seen, waiting for SCL to drop
    AcquireStart,
    // Shifting in the address byte
    AddrRead,
    // Address ACK, hold time then drive low through the ninth clock
    AddrAckWait,
    AddrAckSetup,
    AddrAckPulse,
    AddrAckHold,
    // Read data, one bit per pass through Setup, Pulse and Hold
    TransmitSetup,
    TransmitPulse,
    TransmitHold,
    // Host ACK or NACK of a read byte
    TransmitAck,
    TransmitAckPulse,
    // Write data from the host
    AcquireByte,
    // Data ACK, same sequence as the address ACK
    AcquireAckWait,
    AcquireAckSetup,
    AcquireAckPulse,
    AcquireAckHold,
    // Not addressed, NACKed or abandoned until the next Stop
    WaitForStop
  } state_e;

  // Format code carried in the top bits of a receive entry
  localparam int RxFmtWidth = 2;

  typedef enum logic [RxFmtWidth-1:0] {
    AcqData    = 2'b00,
    AcqStart   = 2'b01,
    AcqStop    = 2'b10,
    AcqRestart = 2'b11
  } rx_fmt_e;

  // Format code above the byte
  localparam int RxEntryWidth = RxFmtWidth + ByteWidth;

endpackage

/* source/i3c_bit_decode.sv */
`timescale 1ns/10ps

module i3c_bit_decode
  import i3c_bus_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   scl_i,
  input  logic                   sda_i,
  input  logic                   byte_clr_i,
  output logic                   start_det_o,
  output logic                   stop_det_o,
  output logic                   scl_rise_o,
  output logic                   scl_fall_o,
  output logic                   bit_ack_o,
  output logic                   host_ack_o,
  output logic [BitIdxWidth-1:0] bit_idx_o,
  output bus_byte_u              in_byte_o
);

  // Pin values one clock back
  logic scl_q;
  logic sda_q;
  logic sda_rise;
  logic sda_fall;

  // Position inside the current byte, 8 is the ACK slot
  logic [BitIdxWidth-1:0] bit_idx_q;
  bus_byte_u              in_byte_q;
  logic                   host_ack_q;

  // Bus idles high
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_q <= 1'b1;
      sda_q <= 1'b1;
    end else begin
      scl_q <= scl_i;
      sda_q <= sda_i;
    end
  end

  assign scl_rise_o = scl_i & ~scl_q;
  assign scl_fall_o = ~scl_i & scl_q;
  assign sda_rise   = sda_i & ~sda_q;
  assign sda_fall   = ~sda_i & sda_q;

  // SDA may only move under a high SCL for Start and Stop
  // SCL high on both samples keeps an SCL edge out of it
  assign start_det_o = sda_fall & scl_i & scl_q;
  assign stop_det_o  = sda_rise & scl_i & scl_q;

  assign bit_ack_o = (bit_idx_q == BitIdxWidth'(ByteWidth));

  // Counts SCL falls, back to zero after the ACK bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_idx_q <= '0;
    end else if (start_det_o || byte_clr_i) begin
      bit_idx_q <= '0;
    end else if (scl_fall_o) begin
      if (bit_ack_o) begin
        bit_idx_q <= '0;
      end else begin
        bit_idx_q <= bit_idx_q + 1'b1;
      end
    end
  end

  // MSB arrives first, ACK slot is skipped
  always_ff @(posedge clk_i) begin
    if (byte_clr_i) begin
      in_byte_q.data <= '0;
    end else if (scl_rise_o && !bit_ack_o) begin
      in_byte_q.data <= {in_byte_q.data[ByteWidth-2:0], sda_i};
    end
  end

  // Host pulls SDA low on the ninth clock to ACK
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      host_ack_q <= 1'b0;
    end else if (scl_rise_o && bit_ack_o) begin
      host_ack_q <= ~sda_i;
    end
  end

  assign bit_idx_o  = bit_idx_q;
  assign in_byte_o  = in_byte_q;
  assign host_ack_o = host_ack_q;

  start_stop_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_det_o |-> !stop_det_o);

endmodule

/* source/i3c_target_ctrl.sv */
`timescale 1ns/10ps

module i3c_target_ctrl
  import i3c_bus_pkg::*;
  import i3c_target_pkg::*;
#(
  parameter int TimingWidth = 13
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   target_enable_i,
  input  logic [AddrWidth-1:0]   target_addr_i,
  input  logic [TimingWidth-1:0] thd_dat_i,
  input  logic                   scl_i,
  input  logic                   start_det_i,
  input  logic                   stop_det_i,
  input  logic                   scl_rise_i,
  input  logic                   scl_fall_i,
  input  logic                   bit_ack_i,
  input  bus_byte_u              in_byte_i,
  input  logic                   host_ack_i,
  output logic                   byte_clr_o,
  output state_e                 state_o,
  output logic                   push_addr_o,
  output logic                   is_restart_o,
  output logic                   push_data_o,
  output logic                   push_stop_o,
  output logic                   pop_tx_o,
  output logic                   xfer_for_us_o,
  output logic                   rw_o,
  output logic                   expect_stop_o
);

  state_e                 state_q;
  // Counts down the data hold time after an SCL fall
  logic [TimingWidth-1:0] hold_cnt_q;
  logic                   hold_done;
  // Address matched since the last Start
  logic                   xfer_q;
  logic                   rw_q;
  logic                   restart_q;
  // Host NACKed a read byte, Stop is due
  logic                   expect_stop_q;
  // SCL went high before the ACK was set up
  logic                   nack_q;

  assign hold_done = (hold_cnt_q == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= Idle;
      hold_cnt_q    <= '0;
      xfer_q        <= 1'b0;
      rw_q          <= 1'b0;
      restart_q     <= 1'b0;
      expect_stop_q <= 1'b0;
      nack_q        <= 1'b0;
    end else if (!target_enable_i) begin
      // Disabled target lets go of the bus
      state_q <= Idle;
      xfer_q  <= 1'b0;
      nack_q  <= 1'b0;
    end else if (stop_det_i) begin
      state_q <= Idle;
      xfer_q  <= 1'b0;
      nack_q  <= 1'b0;
    end else if (start_det_i) begin
      state_q       <= AcquireStart;
      // Start outside Idle is a repeated Start
      restart_q     <= (state_q != Idle);
      xfer_q        <= 1'b0;
      expect_stop_q <= 1'b0;
      nack_q        <= 1'b0;
    end else begin
      unique case (state_q)
        AcquireStart: begin
          if (scl_fall_i) state_q <= AddrRead;
        end
        AddrRead: begin
          if (bit_ack_i) begin
            if (in_byte_i.a.addr == target_addr_i) begin
              state_q    <= AddrAckWait;
              hold_cnt_q <= thd_dat_i;
              xfer_q     <= 1'b1;
              rw_q       <= in_byte_i.a.rw;
            end else begin
              state_q <= WaitForStop;
            end
          end
        end
        AddrAckWait, AcquireAckWait: begin
          if (scl_i) nack_q <= 1'b1;
          if (nack_q) begin
            state_q <= WaitForStop;
          end else if (hold_done) begin
            state_q <= (state_q == AddrAckWait) ? AddrAckSetup : AcquireAckSetup;
          end else begin
            hold_cnt_q <= hold_cnt_q - 1'b1;
          end
        end
        AddrAckSetup: begin
          if (scl_rise_i) state_q <= AddrAckPulse;
        end
        AcquireAckSetup: begin
          if (scl_rise_i) state_q <= AcquireAckPulse;
        end
        AddrAckPulse: begin
          if (scl_fall_i) begin
            state_q    <= AddrAckHold;
            hold_cnt_q <= thd_dat_i;
          end
        end
        AcquireAckPulse: begin
          if (scl_fall_i) begin
            state_q    <= AcquireAckHold;
            hold_cnt_q <= thd_dat_i;
          end
        end
        AddrAckHold: begin
          if (hold_done) begin
            state_q <= rw_q ? TransmitSetup : AcquireByte;
          end else begin
            hold_cnt_q <= hold_cnt_q - 1'b1;
          end
        end
        AcquireAckHold: begin
          if (hold_done) begin
            state_q <= AcquireByte;
          end else begin
            hold_cnt_q <= hold_cnt_q - 1'b1;
          end
        end
        TransmitSetup: begin
          if (scl_rise_i) state_q <= TransmitPulse;
        end
        TransmitPulse: begin
          if (scl_fall_i) begin
            state_q    <= TransmitHold;
            hold_cnt_q <= thd_dat_i;
          end
        end
        TransmitHold: begin
          if (hold_done) begin
            // Eighth bit done, the host owns the ACK slot
            state_q <= bit_ack_i ? TransmitAck : TransmitSetup;
          end else begin
            hold_cnt_q <= hold_cnt_q - 1'b1;
          end
        end
        TransmitAck: begin
          if (scl_rise_i) state_q <= TransmitAckPulse;
        end
        TransmitAckPulse: begin
          if (scl_fall_i) begin
            if (host_ack_i) begin
              state_q    <= TransmitHold;
              hold_cnt_q <= thd_dat_i;
            end else begin
              state_q       <= WaitForStop;
              expect_stop_q <= 1'b1;
            end
          end
        end
        AcquireByte: begin
          if (bit_ack_i) begin
            state_q    <= AcquireAckWait;
            hold_cnt_q <= thd_dat_i;
          end
        end
        default: begin
          state_q <= state_q;
        end
      endcase
    end
  end

  // Entries go out as the ACK is released
  assign push_addr_o  = (state_q == AddrAckHold) && hold_done;
  assign push_data_o  = (state_q == AcquireAckHold) && hold_done;
  assign push_stop_o  = target_enable_i & stop_det_i & xfer_q;
  assign pop_tx_o     = (state_q == TransmitAckPulse) && scl_fall_i;
  assign byte_clr_o   = push_addr_o | push_data_o | ((state_q == AcquireStart) && scl_fall_i);

  assign state_o       = state_q;
  assign is_restart_o  = restart_q;
  assign xfer_for_us_o = xfer_q;
  assign rw_o          = rw_q;
  assign expect_stop_o = expect_stop_q;

  // Only Start, Stop or a disable lead out of WaitForStop, never into an ACK
  wait_stop_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == WaitForStop && !start_det_i) |=> (state_q inside {WaitForStop, Idle}));

endmodule

/* source/i3c_target_result.sv */
`timescale 1ns/10ps

module i3c_target_result
  import i3c_bus_pkg::*;
  import i3c_target_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    target_enable_i,
  input  state_e                  state_i,
  input  bus_byte_u               in_byte_i,
  input  logic [BitIdxWidth-1:0]  bit_idx_i,
  input  logic                    push_addr_i,
  input  logic                    is_restart_i,
  input  logic                    push_data_i,
  input  logic                    push_stop_i,
  input  logic                    pop_tx_i,
  input  logic                    xfer_for_us_i,
  input  logic                    rw_i,
  input  logic                    expect_stop_i,
  input  logic [ByteWidth-1:0]    tx_data_i,
  input  logic                    stop_det_i,
  input  logic                    start_det_i,
  output logic                    sda_o,
  output logic                    target_idle_o,
  output logic                    target_transmitting_o,
  output logic                    rx_valid_o,
  output logic [RxEntryWidth-1:0] rx_data_o,
  output logic                    tx_ready_o,
  output logic                    event_cmd_complete_o,
  output logic                    event_unexp_stop_o
);

  localparam int SelWidth = $clog2(ByteWidth);

  // Bit of tx_data_i on the wire, MSB first
  logic [SelWidth-1:0] tx_sel;
  logic                sda_d;
  logic                sda_q;
  // High while the target itself owns SDA
  logic                drive_d;
  logic                drive_q;
  rx_fmt_e             rx_fmt;

  assign tx_sel = SelWidth'(ByteWidth - 1) - bit_idx_i[SelWidth-1:0];

  always_comb begin
    sda_d   = 1'b1;
    drive_d = 1'b0;
    unique case (state_i)
      // ACK is SDA low from setup until the hold time after the ninth clock
      AddrAckSetup, AddrAckPulse, AddrAckHold,
      AcquireAckSetup, AcquireAckPulse, AcquireAckHold: begin
        sda_d   = 1'b0;
        drive_d = 1'b1;
      end
      // New bit goes out while SCL is low
      TransmitSetup: begin
        sda_d   = tx_data_i[tx_sel];
        drive_d = 1'b1;
      end
      // Bit stays put through SCL high and its hold time
      // After a host ACK this keeps SDA released until the next setup
      TransmitPulse, TransmitHold: begin
        sda_d   = sda_q;
        drive_d = drive_q;
      end
      default: begin
        sda_d   = 1'b1;
        drive_d = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sda_q   <= 1'b1;
      drive_q <= 1'b0;
    end else begin
      sda_q   <= sda_d;
      drive_q <= drive_d;
    end
  end

  assign sda_o                 = sda_q;
  assign target_transmitting_o = drive_q;
  assign target_idle_o         = (state_i == Idle);

  // Stop outranks the rest, though the pushes never meet in practice
  always_comb begin
    rx_fmt = AcqData;
    if (push_stop_i) begin
      rx_fmt = AcqStop;
    end else if (push_addr_i) begin
      rx_fmt = is_restart_i ? AcqRestart : AcqStart;
    end
  end

  assign rx_valid_o = push_addr_i | push_data_i | push_stop_i;
  // Byte field of a Stop entry is whatever was last shifted in
  assign rx_data_o  = {rx_fmt, in_byte_i.data};
  assign tx_ready_o = pop_tx_i;

  // Transfer ends on Stop or repeated Start
  assign event_cmd_complete_o = target_enable_i & xfer_for_us_i & (stop_det_i | start_det_i);

  // Host should NACK the last read byte before its Stop
  assign event_unexp_stop_o = target_enable_i & xfer_for_us_i & rw_i & stop_det_i &
                              ~expect_stop_i;

  // Pushes sit in write and Stop phases, pops only in a read
  rx_tx_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rx_valid_o && tx_ready_o));

endmodule

/* source/i3c_target.sv */
`timescale 1ns/10ps

module i3c_target
  import i3c_bus_pkg::*;
  import i3c_target_pkg::*;
#(
  parameter int TimingWidth = 13
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    target_enable_i,
  input  logic [AddrWidth-1:0]    target_addr_i,
  input  logic [TimingWidth-1:0]  thd_dat_i,
  input  logic                    scl_i,
  input  logic                    sda_i,
  output logic                    sda_o,
  input  logic [ByteWidth-1:0]    tx_data_i,
  output logic                    tx_ready_o,
  output logic                    rx_valid_o,
  output logic [RxEntryWidth-1:0] rx_data_o,
  output logic                    target_idle_o,
  output logic                    target_transmitting_o,
  output logic                    event_cmd_complete_o,
  output logic                    event_unexp_stop_o
);

  // Decode to control
  logic                   start_det;
  logic                   stop_det;
  logic                   scl_rise;
  logic                   scl_fall;
  logic                   bit_ack;
  logic                   host_ack;
  logic [BitIdxWidth-1:0] bit_idx;
  bus_byte_u              in_byte;

  // Control back to decode
  logic byte_clr;

  // Control to result
  state_e state;
  logic   push_addr;
  logic   is_restart;
  logic   push_data;
  logic   push_stop;
  logic   pop_tx;
  logic   xfer_for_us;
  logic   rw_q;
  logic   expect_stop;

  i3c_bit_decode i3c_bit_decode_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .scl_i       (scl_i),
    .sda_i       (sda_i),
    .byte_clr_i  (byte_clr),
    .start_det_o (start_det),
    .stop_det_o  (stop_det),
    .scl_rise_o  (scl_rise),
    .scl_fall_o  (scl_fall),
    .bit_ack_o   (bit_ack),
    .host_ack_o  (host_ack),
    .bit_idx_o   (bit_idx),
    .in_byte_o   (in_byte)
  );

  i3c_target_ctrl #(
    .TimingWidth (TimingWidth)
  ) i3c_target_ctrl_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .target_enable_i (target_enable_i),
    .target_addr_i   (target_addr_i),
    .thd_dat_i       (thd_dat_i),
    .scl_i           (scl_i),
    .start_det_i     (start_det),
    .stop_det_i      (stop_det),
    .scl_rise_i      (scl_rise),
    .scl_fall_i      (scl_fall),
    .bit_ack_i       (bit_ack),
    .in_byte_i       (in_byte),
    .host_ack_i      (host_ack),
    .byte_clr_o      (byte_clr),
    .state_o         (state),
    .push_addr_o     (push_addr),
    .is_restart_o    (is_restart),
    .push_data_o     (push_data),
    .push_stop_o     (push_stop),
    .pop_tx_o        (pop_tx),
    .xfer_for_us_o   (xfer_for_us),
    .rw_o            (rw_q),
    .expect_stop_o   (expect_stop)
  );

  i3c_target_result i3c_target_result_inst (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .target_enable_i       (target_enable_i),
    .state_i               (state),
    .in_byte_i             (in_byte),
    .bit_idx_i             (bit_idx),
    .push_addr_i           (push_addr),
    .is_restart_i          (is_restart),
    .push_data_i           (push_data),
    .push_stop_i           (push_stop),
    .pop_tx_i              (pop_tx),
    .xfer_for_us_i         (xfer_for_us),
    .rw_i                  (rw_q),
    .expect_stop_i         (expect_stop),
    .tx_data_i             (tx_data_i),
    .stop_det_i            (stop_det),
    .start_det_i           (start_det),
    .sda_o                 (sda_o),
    .target_idle_o         (target_idle_o),
    .target_transmitting_o (target_transmitting_o),
    .rx_valid_o            (rx_valid_o),
    .rx_data_o             (rx_data_o),
    .tx_ready_o            (tx_ready_o),
    .event_cmd_complete_o  (event_cmd_complete_o),
    .event_unexp_stop_o    (event_unexp_stop_o)
  );

endmodule

/* dv/i3c_target_tb.sv */
`timescale 1ns/10ps

module i3c_target_tb
  import i3c_bus_pkg::*;
  import i3c_target_pkg::*;
();

  localparam int TimingWidth = 13;
  // SCL half period in clocks
  localparam int HalfClks = 8;
  localparam logic [AddrWidth-1:0] OwnAddr = 7'h3a;

  logic                    clk;
  logic                    rst_n;
  logic                    target_enable;
  logic [AddrWidth-1:0]    target_addr;
  logic [TimingWidth-1:0]  thd_dat;
  logic                    scl;
  // Host side of the open-drain SDA
  logic                    sda_m;
  logic                    sda_bus;
  logic                    sda_o;
  logic [ByteWidth-1:0]    tx_data;
  logic                    tx_ready;
  logic                    rx_valid;
  logic [RxEntryWidth-1:0] rx_data;
  logic                    target_idle;
  logic                    target_transmitting;
  logic                    event_cmd_complete;
  logic                    event_unexp_stop;

  // Vector columns
  int                      vec_op[$];
  int                      vec_en[$];
  logic [AddrWidth-1:0]    vec_addr[$];
  int                      vec_n[$];
  logic [4*ByteWidth-1:0]  vec_bytes[$];
  logic                    vec_ack[$];

  // Observed at the falling clock edge
  logic [RxEntryWidth-1:0] got_rx[$];
  int rx_ptr = 0;
  int cmd_cnt = 0;
  int unexp_cnt = 0;
  int pop_cnt = 0;
  int idle_low_cnt = 0;
  int drive_cnt = 0;
  int cycles = 0;
  int cycle_limit = 100000;

  // Wired AND of host and target
  assign sda_bus = sda_m & sda_o;

  i3c_target #(
    .TimingWidth (TimingWidth)
  ) i3c_target_inst (
    .clk_i                 (clk),
    .rst_ni                (rst_n),
    .target_enable_i       (target_enable),
    .target_addr_i         (target_addr),
    .thd_dat_i             (thd_dat),
    .scl_i                 (scl),
    .sda_i                 (sda_bus),
    .sda_o                 (sda_o),
    .tx_data_i             (tx_data),
    .tx_ready_o            (tx_ready),
    .rx_valid_o            (rx_valid),
    .rx_data_o             (rx_data),
    .target_idle_o         (target_idle),
    .target_transmitting_o (target_transmitting),
    .event_cmd_complete_o  (event_cmd_complete),
    .event_unexp_stop_o    (event_unexp_stop)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "run stopped at first error");
  endtask

  // Strobes and entries are stable mid cycle
  always @(negedge clk) begin
    if (rx_valid) got_rx.push_back(rx_data);
    if (event_cmd_complete) cmd_cnt++;
    if (event_unexp_stop) unexp_cnt++;
    if (tx_ready) pop_cnt++;
    if (!target_idle) idle_low_cnt++;
    if (target_transmitting) drive_cnt++;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) fail_run("Timeout: run exceeded its cycle budget");
  end

  task automatic compare_rx_entry(input string name, input logic [RxEntryWidth-1:0] exp_v,
                                  input logic [RxEntryWidth-1:0] act_v);
    if (exp_v !== act_v) fail_run($sformatf("[ERROR] %s expected %h actual %h", name, exp_v, act_v));
  endtask

  task automatic compare_bus_byte(input string name, input bus_byte_u exp_v,
                                  input bus_byte_u act_v);
    if (exp_v.data !== act_v.data) begin
      fail_run($sformatf("[ERROR] %s expected %h actual %h", name, exp_v.data, act_v.data));
    end
  endtask

  task automatic compare_flag(input string name, input logic exp_v, input logic act_v);
    if (exp_v !== act_v) fail_run($sformatf("[ERROR] %s expected %b actual %b", name, exp_v, act_v));
  endtask

  task automatic compare_count(input string name, input int exp_v, input int act_v);
    if (exp_v != act_v) fail_run($sformatf("[ERROR] %s expected %0d actual %0d", name, exp_v, act_v));
  endtask

  // Inputs move 2 ns after the rising edge
  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  // Plain or repeated Start, SCL ends low
  task automatic send_start();
    if (!scl) begin
      wait_clks(HalfClks / 2);
      sda_m = 1'b1;
      wait_clks(HalfClks / 2);
      scl = 1'b1;
    end
    wait_clks(HalfClks / 2);
    sda_m = 1'b0;
    wait_clks(HalfClks / 2);
    scl = 1'b0;
  endtask

  task automatic send_stop();
    wait_clks(HalfClks / 2);
    sda_m = 1'b0;
    wait_clks(HalfClks / 2);
    scl = 1'b1;
    wait_clks(HalfClks / 2);
    sda_m = 1'b1;
    wait_clks(HalfClks);
  endtask

  // Data set mid low phase, bus sampled mid high phase
  task automatic clock_bit(input logic bit_val, output logic seen);
    wait_clks(HalfClks / 2);
    sda_m = bit_val;
    wait_clks(HalfClks / 2);
    scl = 1'b1;
    wait_clks(HalfClks / 2);
    seen = sda_bus;
    wait_clks(HalfClks / 2);
    scl = 1'b0;
  endtask

  task automatic write_byte(input logic [ByteWidth-1:0] b, output logic acked);
    logic seen;
    for (int i = ByteWidth - 1; i >= 0; i--) clock_bit(b[i], seen);
    clock_bit(1'b1, seen);
    acked = ~seen;
  endtask

  task automatic read_byte(input logic host_ack, output bus_byte_u got);
    logic seen;
    for (int i = ByteWidth - 1; i >= 0; i--) begin
      clock_bit(1'b1, seen);
      got.data[i] = seen;
    end
    clock_bit(~host_ack, seen);
  endtask

  task automatic run_transfer(input int idx);
    string                   name;
    logic                    acked;
    logic                    rd;
    logic                    ack_exp;
    logic [AddrWidth-1:0]    addr;
    logic [RxEntryWidth-1:0] exp_rx[$];
    logic [RxEntryWidth-1:0] act;
    logic [ByteWidth-1:0]    b;
    bus_byte_u               got;
    bus_byte_u               want;
    int                      op;
    int                      n_wr;
    int                      n_rd;
    int                      cmd_base;
    int                      unexp_base;
    int                      pop_base;
    int                      idle_base;
    int                      drive_base;
    name = $sformatf("vector %0d", idx);
    op = vec_op[idx];
    addr = vec_addr[idx];
    ack_exp = vec_ack[idx];
    rd = (op == 1 || op == 3);
    n_wr = rd ? 0 : ((op == 2) ? 1 : vec_n[idx]);
    n_rd = vec_n[idx] - n_wr;
    target_enable = (vec_en[idx] != 0);
    cmd_base = cmd_cnt;
    unexp_base = unexp_cnt;
    pop_base = pop_cnt;
    idle_base = idle_low_cnt;
    drive_base = drive_cnt;
    // First read byte must be ready before the address ACK ends
    tx_data = vec_bytes[idx][n_wr*ByteWidth +: ByteWidth];
    send_start();
    write_byte({addr, rd}, acked);
    compare_flag({name, " address ACK"}, ack_exp, acked);
    if (ack_exp) begin
      exp_rx.push_back({AcqStart, addr, rd});
      for (int i = 0; i < n_wr; i++) begin
        b = vec_bytes[idx][i*ByteWidth +: ByteWidth];
        write_byte(b, acked);
        compare_flag({name, " data ACK"}, 1'b1, acked);
        exp_rx.push_back({AcqData, b});
      end
      if (op == 2) begin
        send_start();
        compare_count({name, " completion at repeated Start"}, 1, cmd_cnt - cmd_base);
        write_byte({addr, 1'b1}, acked);
        compare_flag({name, " read address ACK"}, 1'b1, acked);
        exp_rx.push_back({AcqRestart, addr, 1'b1});
      end
      for (int i = 0; i < n_rd; i++) begin
        tx_data = vec_bytes[idx][(n_wr+i)*ByteWidth +: ByteWidth];
        want.data = tx_data;
        // Host NACKs the last byte unless the read is cut short
        read_byte((op == 3) || (i != n_rd - 1), got);
        compare_bus_byte({name, " read byte"}, want, got);
      end
      // All ones keeps SDA released for the Stop
      tx_data = '1;
      exp_rx.push_back({AcqStop, ByteWidth'(0)});
    end
    send_stop();
    compare_flag({name, " SDA released after Stop"}, 1'b0, target_transmitting);
    compare_flag({name, " target drove SDA"}, ack_exp, (drive_cnt - drive_base) != 0);
    compare_count({name, " receive entries"}, exp_rx.size(), got_rx.size() - rx_ptr);
    foreach (exp_rx[i]) begin
      act = got_rx[rx_ptr];
      // Byte field of a Stop entry carries no meaning
      if (exp_rx[i][RxEntryWidth-1 -: RxFmtWidth] == AcqStop) act[ByteWidth-1:0] = '0;
      compare_rx_entry({name, " receive entry"}, exp_rx[i], act);
      rx_ptr++;
    end
    compare_count({name, " command completions"}, ack_exp ? ((op == 2) ? 2 : 1) : 0,
                  cmd_cnt - cmd_base);
    compare_count({name, " unexpected Stops"}, (ack_exp && op == 3) ? 1 : 0,
                  unexp_cnt - unexp_base);
    compare_count({name, " transmit pops"}, ack_exp ? n_rd : 0, pop_cnt - pop_base);
    if (!target_enable) compare_count({name, " busy cycles while disabled"}, 0,
                                      idle_low_cnt - idle_base);
    target_enable = 1'b1;
  endtask

  task automatic read_vectors();
    string                line;
    int                   fd;
    int                   code;
    int                   op;
    int                   en;
    int                   n;
    int                   ack;
    int                   bits;
    logic [AddrWidth-1:0] addr;
    logic [ByteWidth-1:0] b0;
    logic [ByteWidth-1:0] b1;
    logic [ByteWidth-1:0] b2;
    logic [ByteWidth-1:0] b3;
    bits = 0;
    fd = $fopen("dv/i3c_target_vectors.txt", "r");
    if (fd == 0) fail_run("Could not open the vector file");
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 1 && line.getc(0) != "#") begin
        code = $sscanf(line, "%h %h %h %h %h %h %h %h %h", op, en, addr, n, b0, b1, b2, b3, ack);
        if (code != 9) fail_run("Malformed line in the vector file");
        vec_op.push_back(op);
        vec_en.push_back(en);
        vec_addr.push_back(addr);
        vec_n.push_back(n);
        vec_bytes.push_back({b3, b2, b1, b0});
        vec_ack.push_back(ack != 0);
        // Address and data bytes, a spare byte for a repeated Start, Start and Stop
        bits += 9 * (n + 2) + 4;
      end
    end
    $fclose(fd);
    cycle_limit = bits * 2 * HalfClks + 200;
  endtask

  initial begin
    rst_n = 1'b0;
    target_enable = 1'b1;
    target_addr = OwnAddr;
    thd_dat = TimingWidth'(2);
    scl = 1'b1;
    sda_m = 1'b1;
    tx_data = '1;
    read_vectors();
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    wait_clks(HalfClks);
    compare_flag("idle after reset", 1'b1, target_idle);
    compare_flag("SDA released after reset", 1'b1, sda_o);
    compare_flag("not transmitting after reset", 1'b0, target_transmitting);
    foreach (vec_op[i]) run_transfer(i);
    wait_clks(HalfClks);
    if (got_rx.size() != rx_ptr) begin
      fail_run("Receive entries appeared after the last transfer");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

/* compile.f */
source/i3c_bus_pkg.sv
source/i3c_target_pkg.sv
source/i3c_bit_decode.sv
source/i3c_target_ctrl.sv
source/i3c_target_result.sv
source/i3c_target.sv
dv/i3c_target_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := i3c_target_tb
FILELIST := compile.f
OBJ_DIR  := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the simulation"
	@echo "  clean  remove the build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* dv/i3c_target_vectors.txt */
# op: 0 write, 1 read, 2 write then repeated Start read, 3 read ended by Stop after ACK
# columns (hex): op enable addr count byte0 byte1 byte2 byte3 expected_ack, target addr 3a
# op 2 writes byte0 and reads the rest of count
0 1 3a 2 a5 3c 00 00 1
1 1 3a 2 c3 5a 00 00 1
0 1 21 1 77 00 00 00 0
2 1 3a 2 11 e4 00 00 1
3 1 3a 1 96 00 00 00 1
0 0 3a 1 42 00 00 00 0
1 1 3a 3 01 80 7e 00 1
0 1 3a 4 de ad be ef 1
